/* hdl/accel_pkg.sv */
package accel_pkg;

  localparam int IO_ADDR_WIDTH = 9;
  localparam int IO_DATA_WIDTH = 32;
  localparam int LEN_WIDTH     = 14;

  // Two views of the same I/O address
  typedef union packed {
    struct packed {
      logic       hash_sel;
      logic [3:0] rsvd;
      logic [1:0] hash_op;
      logic [1:0] byte_off;
    } hash;
    struct packed {
      logic       hash_sel;
      logic       status_sel;
      logic [2:0] accel_id;
      logic [1:0] reg_sel;
      logic [1:0] byte_off;
    } cmd;
  } io_addr_u;

  localparam logic [1:0] HASH_OP_CLEAR = 2'd0;
  localparam logic [1:0] HASH_OP_LEN1  = 2'd1;
  localparam logic [1:0] HASH_OP_LEN2  = 2'd2;
  localparam logic [1:0] HASH_OP_LEN4  = 2'd3;

  localparam logic [319:0] TOEPLITZ_KEY =
    320'h6d5a56da255b0ec24167253d43a38fb0d0ca2bcbae7b30b477cb2da38030f20c6a42b73bbeac01fa;

endpackage

/* hdl/accel_regs.sv */
`timescale 1ns/1ps

module accel_regs #(
  parameter int  ACCEL_COUNT    = 4,
  parameter int  MEM_ADDR_WIDTH = 8,
  parameter int  DATA_WIDTH     = 64,
  localparam int ACCEL_W        = (ACCEL_COUNT > 1) ? $clog2(ACCEL_COUNT) : 1
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  io_en,
  input  logic                                  io_wen,
  input  logic [accel_pkg::IO_DATA_WIDTH/8-1:0] io_strb,
  input  logic [accel_pkg::IO_ADDR_WIDTH-1:0]   io_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]   io_wr_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]   io_rd_data,
  output logic                                  io_rd_valid,
  output logic                                  desc_valid,
  output logic [ACCEL_W-1:0]                    desc_accel,
  output logic [MEM_ADDR_WIDTH-1:0]             desc_addr,
  output logic [accel_pkg::LEN_WIDTH-1:0]       desc_len,
  output logic [ACCEL_COUNT-1:0]                lane_stop,
  input  logic [ACCEL_COUNT-1:0]                lane_busy,
  input  logic                                  desc_reject,
  input  logic [ACCEL_COUNT-1:0]                byte_valid,
  input  logic [ACCEL_COUNT-1:0]                byte_last,
  input  logic [ACCEL_COUNT-1:0]                match,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]   hash_data,
  output logic [2:0]                            hash_len,
  output logic                                  hash_valid,
  output logic                                  hash_clear,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]   hash_out,
  output logic                                  error,
  input  logic                                  error_ack
);
  import accel_pkg::*;

  // Word address sits above the byte offset bits
  localparam int BYTE_SHIFT = $clog2(DATA_WIDTH / 8);

  io_addr_u                  addr;
  logic                      wr_cmd;
  logic                      rd_cmd;
  logic                      lane_ok;
  logic [ACCEL_W-1:0]        lane;
  logic [LEN_WIDTH-1:0]      len_reg;
  logic [MEM_ADDR_WIDTH-1:0] addr_reg;
  logic [ACCEL_COUNT-1:0]    status_done;
  logic [ACCEL_COUNT-1:0]    status_match;
  logic [ACCEL_COUNT-1:0]    start_vec;
  logic [ACCEL_COUNT-1:0]    zero_vec;
  logic                      hash_stall;
  logic [IO_DATA_WIDTH-1:0]  rd_word;

  assign addr      = io_addr;
  assign wr_cmd    = io_en && io_wen;
  assign rd_cmd    = io_en && !io_wen;
  assign lane_ok   = int'(addr.cmd.accel_id) < ACCEL_COUNT;
  assign lane      = addr.cmd.accel_id[ACCEL_W-1:0];
  assign desc_addr = addr_reg;
  assign desc_len  = len_reg;

  // ----------------------------------------
  // Bus writes and command pulses
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid <= 1'b0;
      lane_stop  <= '0;
      hash_valid <= 1'b0;
      hash_clear <= 1'b0;
      len_reg    <= '0;
      addr_reg   <= '0;
    end else begin
      desc_valid <= 1'b0;
      lane_stop  <= '0;
      hash_valid <= 1'b0;
      hash_clear <= 1'b0;
      if (wr_cmd && addr.hash.hash_sel) begin
        hash_data <= io_wr_data;
        case (addr.hash.hash_op)
          HASH_OP_CLEAR: hash_clear <= 1'b1;
          HASH_OP_LEN1: begin
            hash_len   <= 3'd1;
            hash_valid <= 1'b1;
          end
          HASH_OP_LEN2: begin
            hash_len   <= 3'd2;
            hash_valid <= 1'b1;
          end
          HASH_OP_LEN4: begin
            hash_len   <= 3'd4;
            hash_valid <= 1'b1;
          end
        endcase
      end else if (wr_cmd && !addr.cmd.status_sel && lane_ok) begin
        case (addr.cmd.reg_sel)
          2'd0: begin
            if (io_strb[0]) begin
              desc_valid      <= io_wr_data[0];
              desc_accel      <= lane;
              lane_stop[lane] <= io_wr_data[4];
            end
          end
          2'd1: len_reg <= io_wr_data[LEN_WIDTH-1:0];
          2'd2: addr_reg <= io_wr_data[BYTE_SHIFT +: MEM_ADDR_WIDTH];
          default: ;
        endcase
      end
    end
  end

  // ----------------------------------------
  // Sticky lane status and error latch
  // ----------------------------------------
  always_comb begin
    start_vec = '0;
    zero_vec  = '0;
    if (desc_valid && !desc_reject) begin
      start_vec[desc_accel] = 1'b1;
      // Empty job finishes at once
      zero_vec[desc_accel]  = (len_reg == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      status_done  <= '0;
      status_match <= '0;
      error        <= 1'b0;
    end else begin
      status_done  <= (status_done & ~start_vec) | (byte_valid & byte_last) |
                      lane_stop | zero_vec;
      status_match <= (status_match & ~start_vec) | match;
      error        <= desc_reject | (error && !error_ack);
    end
  end

  // ----------------------------------------
  // Read data
  // ----------------------------------------
  always_comb begin
    rd_word = '0;
    if (addr.cmd.status_sel) begin
      rd_word[ACCEL_COUNT-1:0] = status_done | status_match;
    end else if (lane_ok) begin
      case (addr.cmd.reg_sel)
        2'd0: begin
          rd_word[1] = lane_busy[lane];
          rd_word[8] = status_done[lane];
          rd_word[9] = status_match[lane];
        end
        2'd1: rd_word[LEN_WIDTH-1:0] = len_reg;
        2'd2: rd_word[BYTE_SHIFT +: MEM_ADDR_WIDTH] = addr_reg;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      io_rd_valid <= 1'b0;
      hash_stall  <= 1'b0;
    end else begin
      io_rd_valid <= 1'b0;
      hash_stall  <= 1'b0;
      if (hash_stall) begin
        io_rd_data  <= hash_out;
        io_rd_valid <= 1'b1;
      end
      if (rd_cmd && addr.hash.hash_sel) begin
        // Hash still updating, answer one cycle later
        if (hash_valid || hash_clear) begin
          hash_stall <= 1'b1;
        end else begin
          io_rd_data  <= hash_out;
          io_rd_valid <= 1'b1;
        end
      end else if (rd_cmd) begin
        io_rd_data  <= rd_word;
        io_rd_valid <= 1'b1;
      end
    end
  end

endmodule

/* hdl/accel_rd_dma.sv */
`timescale 1ns/1ps

module accel_rd_dma #(
  parameter int  ACCEL_COUNT    = 4,
  parameter int  DATA_WIDTH     = 64,
  parameter int  MEM_ADDR_WIDTH = 8,
  localparam int ACCEL_W        = (ACCEL_COUNT > 1) ? $clog2(ACCEL_COUNT) : 1,
  localparam int BYTES          = DATA_WIDTH / 8,
  localparam int CNT_W          = $clog2(BYTES + 1)
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            desc_valid,
  input  logic [ACCEL_W-1:0]              desc_accel,
  input  logic [MEM_ADDR_WIDTH-1:0]       desc_addr,
  input  logic [accel_pkg::LEN_WIDTH-1:0] desc_len,
  input  logic [ACCEL_COUNT-1:0]          lane_stop,
  output logic [ACCEL_COUNT-1:0]          lane_busy,
  output logic                            desc_reject,
  output logic                            mem_rd_en,
  output logic [MEM_ADDR_WIDTH-1:0]       mem_rd_addr,
  input  logic [DATA_WIDTH-1:0]           mem_rd_data,
  output logic [DATA_WIDTH-1:0]           str_data,
  output logic [CNT_W-1:0]                str_bytes,
  output logic                            str_last,
  output logic [ACCEL_COUNT-1:0]          str_valid,
  input  logic [ACCEL_COUNT-1:0]          str_ready
);
  import accel_pkg::*;

  localparam logic [LEN_WIDTH-1:0] BYTES_L = LEN_WIDTH'(BYTES);

  logic                      busy;
  logic [ACCEL_W-1:0]        active;
  logic [LEN_WIDTH-1:0]      words_left;
  logic [MEM_ADDR_WIDTH-1:0] rd_addr;
  logic                      rd_pend;
  logic                      rd_pend_last;
  logic                      buf_valid;
  logic                      buf_last;
  logic [DATA_WIDTH-1:0]     buf_data;
  logic [CNT_W-1:0]          last_bytes;
  logic [LEN_WIDTH-1:0]      desc_rem;
  logic [LEN_WIDTH-1:0]      desc_words;
  logic [CNT_W-1:0]          desc_tail;
  logic                      accept;
  logic                      stop_now;
  logic                      xfer;

  // Descriptor to word count and tail byte count
  assign desc_rem   = desc_len % BYTES_L;
  assign desc_words = desc_len / BYTES_L + LEN_WIDTH'(desc_rem != '0);
  assign desc_tail  = (desc_rem == '0) ? CNT_W'(BYTES) : desc_rem[CNT_W-1:0];

  assign accept      = desc_valid && !busy && (desc_len != '0);
  assign desc_reject = desc_valid && busy;
  assign stop_now    = busy && lane_stop[active];
  assign xfer        = |(str_valid & str_ready);

  // One read in flight or one word held, never both
  assign mem_rd_en   = busy && !stop_now && (words_left != '0) && !rd_pend && !buf_valid;
  assign mem_rd_addr = rd_addr;

  assign str_data  = buf_data;
  assign str_last  = buf_last;
  assign str_bytes = last_bytes;

  always_comb begin
    for (int i = 0; i < ACCEL_COUNT; i++) begin
      lane_busy[i] = busy && (active == ACCEL_W'(i));
      str_valid[i] = buf_valid && (active == ACCEL_W'(i)) && !lane_stop[i];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      words_left <= '0;
      rd_pend    <= 1'b0;
      buf_valid  <= 1'b0;
    end else begin
      if (accept) begin
        busy       <= 1'b1;
        active     <= desc_accel;
        words_left <= desc_words;
        rd_addr    <= desc_addr;
        last_bytes <= desc_tail;
      end
      rd_pend <= mem_rd_en;
      if (mem_rd_en) begin
        rd_addr      <= rd_addr + 1'b1;
        words_left   <= words_left - 1'b1;
        rd_pend_last <= (words_left == LEN_WIDTH'(1));
      end
      if (rd_pend) begin
        buf_valid <= 1'b1;
        buf_data  <= mem_rd_data;
        buf_last  <= rd_pend_last;
      end
      if (xfer) begin
        buf_valid <= 1'b0;
        if (buf_last) begin
          busy <= 1'b0;
        end
      end
      // Stop drops any read or word still held
      if (stop_now) begin
        busy       <= 1'b0;
        words_left <= '0;
        rd_pend    <= 1'b0;
        buf_valid  <= 1'b0;
      end
    end
  end

endmodule

/* hdl/accel_width_conv.sv */
`timescale 1ns/1ps

module accel_width_conv #(
  parameter int  DATA_WIDTH = 64,
  localparam int BYTES      = DATA_WIDTH / 8,
  localparam int CNT_W      = $clog2(BYTES + 1)
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [DATA_WIDTH-1:0] in_data,
  input  logic [CNT_W-1:0]      in_bytes,
  input  logic                  in_last,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [7:0]            byte_data,
  output logic                  byte_valid,
  output logic                  byte_last
);

  logic                  full;
  logic                  last_word;
  logic [CNT_W-1:0]      remain;
  logic [DATA_WIDTH-1:0] shreg;

  assign in_ready   = !full;
  assign byte_valid = full;
  assign byte_data  = shreg[7:0];
  assign byte_last  = full && last_word && (remain == CNT_W'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      full   <= 1'b0;
      remain <= '0;
    end else if (!full) begin
      if (in_valid) begin
        full      <= 1'b1;
        shreg     <= in_data;
        last_word <= in_last;
        // Short tail only on the final word
        remain    <= in_last ? in_bytes : CNT_W'(BYTES);
      end
    end else begin
      shreg  <= shreg >> 8;
      remain <= remain - 1'b1;
      if (remain == CNT_W'(1)) begin
        full <= 1'b0;
      end
    end
  end

endmodule

/* hdl/pattern_match.sv */
`timescale 1ns/1ps

module pattern_match #(
  parameter logic [31:0] MATCH_PATTERN = 32'h4b4e4950
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       init,
  input  logic [7:0] byte_data,
  input  logic       byte_valid,
  output logic       match
);

  // Oldest byte in the low lane
  logic [23:0] hist;
  logic [1:0]  fill;

  assign match = byte_valid && (fill == 2'd3) && ({byte_data, hist} == MATCH_PATTERN);

  always_ff @(posedge clk) begin
    if (rst) begin
      fill <= 2'd0;
    end else if (init) begin
      fill <= 2'd0;
    end else if (byte_valid) begin
      hist <= {byte_data, hist[23:8]};
      if (fill != 2'd3) begin
        fill <= fill + 2'd1;
      end
    end
  end

endmodule

/* hdl/toeplitz_hash.sv */
`timescale 1ns/1ps

module toeplitz_hash (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] hash_data,
  input  logic [2:0]  hash_len,
  input  logic        hash_valid,
  input  logic        hash_clear,
  output logic [31:0] hash_out
);
  import accel_pkg::*;

  // Key covers 36 input bytes
  localparam int MAX_BITS = 36 * 8;

  logic [31:0] hash_reg;
  logic [31:0] hash_nxt;
  logic [8:0]  pos;
  logic [9:0]  pos_sum;

  assign hash_out = hash_reg;
  assign pos_sum  = 10'(pos) + {4'd0, hash_len, 3'd0};

  always_comb begin
    logic [319:0] key_sh;
    hash_nxt = hash_reg;
    for (int i = 0; i < 32; i++) begin
      // Bytes in order, bits msb first
      key_sh = TOEPLITZ_KEY << (int'(pos) + i);
      if ((i < 8 * int'(hash_len)) && hash_data[8 * (i / 8) + 7 - (i % 8)] &&
          (int'(pos) + i < MAX_BITS)) begin
        hash_nxt = hash_nxt ^ key_sh[319:288];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hash_reg <= '0;
      pos      <= '0;
    end else if (hash_clear) begin
      hash_reg <= '0;
      pos      <= '0;
    end else if (hash_valid) begin
      hash_reg <= hash_nxt;
      pos      <= (pos_sum > 10'(MAX_BITS)) ? 9'(MAX_BITS) : pos_sum[8:0];
    end
  end

endmodule

/* hdl/accel_wrap.sv */
`timescale 1ns/1ps

module accel_wrap #(
  parameter int          ACCEL_COUNT    = 4,
  parameter int          DATA_WIDTH     = 64,
  parameter int          MEM_ADDR_WIDTH = 8,
  parameter logic [31:0] MATCH_PATTERN  = 32'h4b4e4950
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  io_en,
  input  logic                                  io_wen,
  input  logic [accel_pkg::IO_DATA_WIDTH/8-1:0] io_strb,
  input  logic [accel_pkg::IO_ADDR_WIDTH-1:0]   io_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]   io_wr_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]   io_rd_data,
  output logic                                  io_rd_valid,
  output logic                                  mem_rd_en,
  output logic [MEM_ADDR_WIDTH-1:0]             mem_rd_addr,
  input  logic [DATA_WIDTH-1:0]                 mem_rd_data,
  output logic                                  error,
  input  logic                                  error_ack
);
  import accel_pkg::*;

  localparam int ACCEL_W = (ACCEL_COUNT > 1) ? $clog2(ACCEL_COUNT) : 1;
  localparam int CNT_W   = $clog2(DATA_WIDTH / 8 + 1);

  logic                      desc_valid;
  logic [ACCEL_W-1:0]        desc_accel;
  logic [MEM_ADDR_WIDTH-1:0] desc_addr;
  logic [LEN_WIDTH-1:0]      desc_len;
  logic                      desc_reject;
  logic [ACCEL_COUNT-1:0]    lane_stop;
  logic [ACCEL_COUNT-1:0]    lane_busy;
  logic [ACCEL_COUNT-1:0]    lane_init;
  logic [DATA_WIDTH-1:0]     str_data;
  logic [CNT_W-1:0]          str_bytes;
  logic                      str_last;
  logic [ACCEL_COUNT-1:0]    str_valid;
  logic [ACCEL_COUNT-1:0]    str_ready;
  logic [ACCEL_COUNT-1:0]    byte_valid;
  logic [ACCEL_COUNT-1:0]    byte_last;
  logic [ACCEL_COUNT-1:0]    match;
  logic [IO_DATA_WIDTH-1:0]  hash_data;
  logic [2:0]                hash_len;
  logic                      hash_valid;
  logic                      hash_clear;
  logic [IO_DATA_WIDTH-1:0]  hash_out;

  accel_regs #(
    .ACCEL_COUNT(ACCEL_COUNT), .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)
  ) u_regs (
    .clk(clk), .rst(rst), .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb),
    .io_addr(io_addr), .io_wr_data(io_wr_data), .io_rd_data(io_rd_data),
    .io_rd_valid(io_rd_valid), .desc_valid(desc_valid), .desc_accel(desc_accel),
    .desc_addr(desc_addr), .desc_len(desc_len), .lane_stop(lane_stop),
    .lane_busy(lane_busy), .desc_reject(desc_reject), .byte_valid(byte_valid),
    .byte_last(byte_last), .match(match), .hash_data(hash_data), .hash_len(hash_len),
    .hash_valid(hash_valid), .hash_clear(hash_clear), .hash_out(hash_out),
    .error(error), .error_ack(error_ack)
  );

  accel_rd_dma #(
    .ACCEL_COUNT(ACCEL_COUNT), .DATA_WIDTH(DATA_WIDTH), .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
  ) u_dma (
    .clk(clk), .rst(rst), .desc_valid(desc_valid), .desc_accel(desc_accel),
    .desc_addr(desc_addr), .desc_len(desc_len), .lane_stop(lane_stop),
    .lane_busy(lane_busy), .desc_reject(desc_reject), .mem_rd_en(mem_rd_en),
    .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data), .str_data(str_data),
    .str_bytes(str_bytes), .str_last(str_last), .str_valid(str_valid),
    .str_ready(str_ready)
  );

  // ----------------------------------------
  // Per-lane converter and matcher
  // ----------------------------------------
  for (genvar n = 0; n < ACCEL_COUNT; n++) begin : g_lane
    logic [7:0] byte_data;

    assign lane_init[n] = desc_valid && !desc_reject && (desc_accel == ACCEL_W'(n));

    accel_width_conv #(.DATA_WIDTH(DATA_WIDTH)) u_conv (
      .clk(clk), .rst(rst), .in_data(str_data), .in_bytes(str_bytes),
      .in_last(str_last), .in_valid(str_valid[n]), .in_ready(str_ready[n]),
      .byte_data(byte_data), .byte_valid(byte_valid[n]), .byte_last(byte_last[n])
    );

    pattern_match #(.MATCH_PATTERN(MATCH_PATTERN)) u_match (
      .clk(clk), .rst(rst), .init(lane_init[n]), .byte_data(byte_data),
      .byte_valid(byte_valid[n]), .match(match[n])
    );
  end

  toeplitz_hash u_hash (
    .clk(clk), .rst(rst), .hash_data(hash_data), .hash_len(hash_len),
    .hash_valid(hash_valid), .hash_clear(hash_clear), .hash_out(hash_out)
  );

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

/* verif/accel_wrap_tb.sv */
`timescale 1ns/1ps

module accel_wrap_tb;
  import accel_pkg::*;

  localparam int          ACCEL_COUNT = 4;
  localparam int          MEM_WORDS   = 256;
  localparam logic [31:0] PATTERN     = 32'h4b4e4950;
  localparam int          NUM_JOBS    = 40;
  localparam int          MAX_LEN     = 120;
  localparam int          HASH_SEQS   = 12;
  localparam int          HASH_OPS    = HASH_SEQS * 20;
  // Stop and reject cases add four jobs
  localparam int          TIMEOUT     = (NUM_JOBS + 4) * (MAX_LEN + 40) + HASH_OPS * 8 + 2000;

  logic        clk;
  logic        rst;
  logic        io_en;
  logic        io_wen;
  logic [3:0]  io_strb;
  logic [8:0]  io_addr;
  logic [31:0] io_wr_data;
  logic [31:0] io_rd_data;
  logic        io_rd_valid;
  logic        mem_rd_en;
  logic [7:0]  mem_rd_addr;
  logic [63:0] mem_rd_data;
  logic        error;
  logic        error_ack;

  logic [63:0]            mem [MEM_WORDS];
  logic [31:0]            rng;
  logic [7:0]             hash_q [$];
  logic [ACCEL_COUNT-1:0] exp_done;
  logic [ACCEL_COUNT-1:0] exp_match;
  int                     cycles = 0;

  tb_clk_gen #(.PERIOD_NS(4)) u_clk (.clk(clk));

  accel_wrap #(
    .ACCEL_COUNT(ACCEL_COUNT), .DATA_WIDTH(64), .MEM_ADDR_WIDTH(8), .MATCH_PATTERN(PATTERN)
  ) u_dut (
    .clk(clk), .rst(rst), .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb),
    .io_addr(io_addr), .io_wr_data(io_wr_data), .io_rd_data(io_rd_data),
    .io_rd_valid(io_rd_valid), .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr),
    .mem_rd_data(mem_rd_data), .error(error), .error_ack(error_ack)
  );

  // Packet memory with one cycle read latency
  always @(posedge clk) begin
    if (mem_rd_en) begin
      mem_rd_data <= mem[mem_rd_addr];
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      fail_stop($sformatf("Timeout: run passed the limit of %0d cycles", TIMEOUT));
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function logic [31:0] next_random();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task fail_stop(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task bus_write(input logic [8:0] addr, input logic [31:0] data);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_strb    = 4'hf;
    io_addr    = addr;
    io_wr_data = data;
    @(posedge clk);
    #1;
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  task bus_read(input logic [8:0] addr, input int exp_lat, output logic [31:0] data);
    int lat;
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(posedge clk);
    #1;
    io_en = 1'b0;
    lat   = 1;
    while (!io_rd_valid) begin
      if (lat >= 4) begin
        fail_stop("No read response arrived on the bus");
      end
      @(posedge clk);
      #1;
      lat++;
    end
    check("io_rd_valid latency", 64'(lat), 64'(exp_lat));
    data = io_rd_data;
  endtask

  function automatic logic [8:0] lane_reg(input int lane, input int sel);
    return 9'(lane * 16 + sel * 4);
  endfunction

  function automatic logic [7:0] mem_byte(input int wa, input int i);
    return mem[(wa + i / 8) % MEM_WORDS][8 * (i % 8) +: 8];
  endfunction

  task plant_pattern(input int wa, input int off);
    for (int k = 0; k < 4; k++) begin
      mem[(wa + (off + k) / 8) % MEM_WORDS][8 * ((off + k) % 8) +: 8] = PATTERN[8 * k +: 8];
    end
  endtask

  function automatic logic search_model(input int wa, input int len);
    logic found;
    found = 1'b0;
    for (int i = 0; i + 3 < len; i++) begin
      if ({mem_byte(wa, i + 3), mem_byte(wa, i + 2), mem_byte(wa, i + 1), mem_byte(wa, i)}
          == PATTERN) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  function automatic logic [31:0] hash_model();
    logic [31:0]  h;
    logic [319:0] key;
    h = '0;
    for (int j = 0; j < hash_q.size() && j < 36; j++) begin
      for (int b = 0; b < 8; b++) begin
        // Key window starts at the global bit position
        key = TOEPLITZ_KEY << (8 * j + b);
        if (hash_q[j][7 - b]) begin
          h = h ^ key[319:288];
        end
      end
    end
    return h;
  endfunction

  task check_status();
    logic [31:0] d;
    bus_read(9'h080, 1, d);
    check("status 0x080", d, 64'(exp_done | exp_match));
  endtask

  task start_job(input int lane, input int wa, input int len);
    bus_write(lane_reg(lane, 1), 32'(len));
    bus_write(lane_reg(lane, 2), 32'(wa * 8));
    bus_write(lane_reg(lane, 0), 32'h1);
    idle(1);
  endtask

  task finish_job(input int lane, input int wa, input int len);
    logic [31:0] ctrl;
    logic        exp_m;
    do begin
      bus_read(lane_reg(lane, 0), 1, ctrl);
    end while (!ctrl[8]);
    exp_m = search_model(wa, len);
    check("lane control", ctrl, exp_m ? 64'h300 : 64'h100);
    exp_done[lane]  = 1'b1;
    exp_match[lane] = exp_m;
    check_status();
  endtask

  task hash_feed(input int n, input logic [31:0] data);
    logic [1:0] op;
    op = (n == 1) ? HASH_OP_LEN1 : (n == 2) ? HASH_OP_LEN2 : HASH_OP_LEN4;
    bus_write(9'(256 + 4 * int'(op)), data);
    for (int k = 0; k < n; k++) begin
      hash_q.push_back(data[8 * k +: 8]);
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    logic [31:0] d;
    logic [31:0] v;
    int          lane;
    int          wa;
    int          len;
    int          n;
    int          nfeeds;
    rng         = 32'hc4c9;
    rst         = 1'b1;
    io_en       = 1'b0;
    io_wen      = 1'b0;
    io_strb     = '0;
    io_addr     = '0;
    io_wr_data  = '0;
    mem_rd_data <= '0;
    error_ack   = 1'b0;
    exp_done    = '0;
    exp_match   = '0;
    for (int w = 0; w < MEM_WORDS; w++) begin
      mem[w] = {next_random(), next_random()};
    end
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    check("error", error, 0);
    check("io_rd_valid", io_rd_valid, 0);
    check_status();
    for (int i = 0; i < ACCEL_COUNT; i++) begin
      bus_read(lane_reg(i, 0), 1, d);
      check("lane control after reset", d, 0);
    end

    repeat (16) begin
      lane = int'(next_random() % ACCEL_COUNT);
      v    = next_random();
      bus_write(lane_reg(lane, 1), v);
      bus_read(lane_reg(lane, 1), 1, d);
      check("length register", d, v & 32'h3fff);
      v = next_random();
      bus_write(lane_reg(lane, 2), v);
      bus_read(lane_reg(lane, 2), 1, d);
      check("address register", d, v & 32'h7f8);
    end

    // Stop a long job and restart it
    wa = int'(next_random() % MEM_WORDS);
    plant_pattern(wa, 0);
    start_job(0, wa, 800);
    idle(30);
    // Pattern in the first word is already seen
    bus_read(lane_reg(0, 0), 1, d);
    check("lane 0 control while running", d, 32'h202);
    bus_write(lane_reg(0, 0), 32'h10);
    idle(10);
    bus_read(lane_reg(0, 0), 1, d);
    check("lane 0 control after stop", d, 32'h300);
    start_job(0, wa, 800);
    bus_read(lane_reg(0, 0), 1, d);
    check("lane 0 control after restart", d, 32'h2);
    idle(30);
    bus_write(lane_reg(0, 0), 32'h10);
    idle(10);
    bus_read(lane_reg(0, 0), 1, d);
    check("lane 0 control after second stop", d, 32'h300);
    exp_done[0]  = 1'b1;
    exp_match[0] = 1'b1;
    check_status();

    // Second start while lane 1 is busy
    wa = int'(next_random() % MEM_WORDS);
    plant_pattern(wa, 50);
    start_job(1, wa, MAX_LEN);
    bus_write(lane_reg(2, 0), 32'h1);
    idle(1);
    check("error after reject", error, 1);
    finish_job(1, wa, MAX_LEN);
    check("error held", error, 1);
    error_ack = 1'b1;
    @(posedge clk);
    #1;
    error_ack = 1'b0;
    check("error after ack", error, 0);

    for (int j = 0; j < NUM_JOBS; j++) begin
      lane = int'(next_random() % ACCEL_COUNT);
      wa   = int'(next_random() % MEM_WORDS);
      len  = int'(next_random() % MAX_LEN) + 1;
      v    = next_random();
      if (v[0] && len >= 4) begin
        plant_pattern(wa, int'(next_random() % 32'(len - 3)));
      end
      start_job(lane, wa, len);
      finish_job(lane, wa, len);
    end

    for (int s = 0; s < HASH_SEQS; s++) begin
      bus_write(9'h100, next_random());
      hash_q.delete();
      idle(1);
      nfeeds = int'(next_random() % 9) + 1;
      for (int f = 0; f < nfeeds; f++) begin
        case (next_random() % 3)
          0: n = 1;
          1: n = 2;
          default: n = 4;
        endcase
        hash_feed(n, next_random());
        v = next_random();
        if (v[0]) begin
          bus_read(9'h100, 2, d);
        end else begin
          idle(1);
          bus_read(9'h100, 1, d);
        end
        check("hash_out", d, hash_model());
      end
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* accel_wrap.f */
hdl/accel_pkg.sv
hdl/accel_regs.sv
hdl/accel_rd_dma.sv
hdl/accel_width_conv.sv
hdl/pattern_match.sv
hdl/toeplitz_hash.sv
hdl/accel_wrap.sv
verif/tb_clk_gen.sv
verif/accel_wrap_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary -j 0 -Wno-fatal
TOP       = accel_wrap_tb
FILELIST  = accel_wrap.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
